// File: alsLight.f
+incdir+verilog
verilog/alsPkg.sv
verilog/sckDivider.sv
verilog/alsSpiReader.sv
verilog/sampleAverager.sv
verilog/lightClassifier.sv
verilog/alsTop.sv
testbench/alsTb.sv

// File: testbench/alsInput.txt
// value mean level, one frame per line, all hex
// level 0 dark, 1 dim, 2 bright, 3 sun
10 04 00
40 14 00
c0 44 01
c0 74 01
c0 a0 02
c0 c0 03
bf bf 02
80 af 02
80 9f 02
80 8f 02
80 80 02
7f 7f 01
40 6f 01
00 4f 01
41 40 01
7d 3f 00
ff 6f 01
ff af 02

// File: testbench/alsTb.sv
// Light sensor pipeline testbench
`include "als_defs.svh"

module alsTb;

    import alsPkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_FRAMES      = 18;
    localparam int BP_START        = 8;
    localparam int LATENCY         = 3;
    localparam int FRAME_CYCLES    = (`ALS_FRAME_BITS + `ALS_QUERY_GAP) * 2 * `ALS_SCK_HALF;
    localparam int WATCHDOG_CYCLES = (NUM_FRAMES + 2) * FRAME_CYCLES + 1000;

    logic         clk;
    logic         rstN;
    logic         cs;
    logic         sck;
    logic         sdo;
    logic         creditReturn;
    lightReport_t report;
    logic         reportValid;

    // Value, mean and level for each frame
    logic [7:0]   vecMem [0:3*NUM_FRAMES-1];
    logic [31:0]  lfsrState;
    int           cycle;
    int           checks;
    int           errors;
    int           tests;
    int           framesStarted;
    int           framesDone;
    int           edgeCnt;
    int           edgeCycle;
    int           edgeCredits;
    int           bitIdx;
    int           reportsSeen;
    int           returnsIssued;
    int           lastSeq;
    int           dueQ[$];
    logic [7:0]   curVal;
    logic         prevCs;
    logic         prevSck;
    logic         doneFlag;

    alsTop u_dut (
        .clk          (clk),
        .rstN         (rstN),
        .cs           (cs),
        .sck          (sck),
        .sdo          (sdo),
        .report       (report),
        .reportValid  (reportValid),
        .creditReturn (creditReturn)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
    end

    // Galois LFSR stepped once per bit taken
    function automatic int randomBits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            val = (val << 1) | lfsrState[0];
        end
        return val;
    endfunction

    // Zero prefix, value MSB first, zero tail
    function automatic logic frameBit(input logic [7:0] v, input int idx);
        if (idx >= `ALS_PREFIX_BITS && idx < `ALS_PREFIX_BITS + `ALS_DATA_BITS) begin
            return v[`ALS_PREFIX_BITS + `ALS_DATA_BITS - 1 - idx];
        end
        return 1'b0;
    endfunction

    task automatic expectEq(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    initial begin
        rstN         = 1'b0;
        sdo          = 1'b0;
        creditReturn = 1'b0;
        prevCs       = 1'b1;
        prevSck      = 1'b0;
        doneFlag     = 1'b0;
        lastSeq      = -1;
        lfsrState    = 32'hf4f564f2;
        $readmemh("testbench/alsInput.txt", vecMem);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        expectEq("cs after reset", cs, 1);
        expectEq("sck after reset", sck, 0);
        expectEq("reportValid after reset", reportValid, 0);
        wait (doneFlag);
        @(negedge clk);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Sensor model, frame monitor, report checks and consumer
    always @(negedge clk) begin : monitor
        lightReport_t r;
        lightLevel_t  lvl;
        readerState_t rdState;
        int           gap;
        int           expDrop;
        int           errBefore;
        if (rstN) begin
            creditReturn = 1'b0;
            if (prevCs && !cs) begin
                curVal = (framesStarted < NUM_FRAMES) ? vecMem[3*framesStarted] : 8'h00;
                bitIdx = 0;
                sdo    = frameBit(curVal, 0);
                // Credits come back one at a time after the slot was overwritten
                if (framesStarted == 15 || framesStarted == 17 || framesStarted == 18) begin
                    dueQ.push_back(cycle + 1 + randomBits(6));
                end
                framesStarted++;
            end else if (prevSck && !sck && !cs) begin
                bitIdx++;
                sdo = frameBit(curVal, bitIdx);
            end
            if (!cs && sck && !prevSck) begin
                edgeCnt++;
                if (edgeCnt == `ALS_FRAME_BITS) begin
                    framesDone++;
                    edgeCycle   = cycle;
                    edgeCredits = `ALS_CREDITS + returnsIssued - reportsSeen;
                end
            end
            if (cs && !prevCs) begin
                expectEq("sck edges in frame", edgeCnt, `ALS_FRAME_BITS);
                edgeCnt = 0;
                sdo     = 1'b0;
            end
            assert (!(cs && sck)) else begin
                $display("Error at %0t: sck went high while cs was high", $time);
                errors++;
            end
            if (reportValid) begin
                r         = report;
                lvl       = r.level;
                rdState   = u_dut.u_reader.state;
                errBefore = errors;
                reportsSeen++;
                tests++;
                assert (reportsSeen <= returnsIssued + `ALS_CREDITS) else begin
                    $display("Error at %0t: a report was sent with no credit left", $time);
                    errors++;
                end
                expectEq("seq", r.seq, framesDone - 1);
                if (r.seq < NUM_FRAMES) begin
                    expectEq("raw", r.raw, vecMem[3*r.seq]);
                    expectEq("mean", r.mean, vecMem[3*r.seq+1]);
                    expectEq("level", r.level, vecMem[3*r.seq+2]);
                end
                gap     = int'(r.seq) - lastSeq;
                expDrop = (gap - 1 > 15) ? 15 : gap - 1;
                expectEq("dropped", r.dropped, expDrop);
                if (edgeCredits > 0 && r.seq == framesDone - 1) begin
                    expectEq("latency", cycle - edgeCycle, LATENCY);
                end
                if (r.seq < BP_START) begin
                    dueQ.push_back(cycle + 1 + randomBits(6));
                end
                $display("Report %0d: raw %02h mean %02h %s dropped %0d, reader %s, %s",
                         r.seq, r.raw, r.mean, lvl.name(), r.dropped, rdState.name(),
                         (errors == errBefore) ? "ok" : "mismatch");
                lastSeq = r.seq;
                if (r.seq == NUM_FRAMES - 1) begin
                    doneFlag = 1'b1;
                end
            end
            if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
                creditReturn = 1'b1;
                void'(dueQ.pop_front());
                returnsIssued++;
            end
            prevCs  = cs;
            prevSck = sck;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the last report did not arrive within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog/alsTop.sv
// Ambient light sensor pipeline
`include "als_defs.svh"

module alsTop (
    input  logic                 clk,
    input  logic                 rstN,
    output logic                 cs,
    output logic                 sck,
    input  logic                 sdo,
    output alsPkg::lightReport_t report,
    output logic                 reportValid,
    input  logic                 creditReturn
);

    import alsPkg::*;

    logic       sckRaw;
    logic       sckRise;
    sample_t    sample;
    logic       sampleValid;
    avgSample_t avg;
    logic       avgValid;

    sckDivider u_sckDivider (
        .clk     (clk),
        .rstN    (rstN),
        .sckRaw  (sckRaw),
        .sckRise (sckRise)
    );

    alsSpiReader #(
        .QUERY_GAP (`ALS_QUERY_GAP)
    ) u_reader (
        .clk         (clk),
        .rstN        (rstN),
        .sckRaw      (sckRaw),
        .sckRise     (sckRise),
        .sdo         (sdo),
        .cs          (cs),
        .sck         (sck),
        .sample      (sample),
        .sampleValid (sampleValid)
    );

    sampleAverager u_averager (
        .clk         (clk),
        .rstN        (rstN),
        .sample      (sample),
        .sampleValid (sampleValid),
        .avg         (avg),
        .avgValid    (avgValid)
    );

    lightClassifier u_classifier (
        .clk          (clk),
        .rstN         (rstN),
        .avg          (avg),
        .avgValid     (avgValid),
        .creditReturn (creditReturn),
        .report       (report),
        .reportValid  (reportValid)
    );

endmodule

// File: verilog/lightClassifier.sv
// Light level classifier with credit flow control
`include "als_defs.svh"

module lightClassifier (
    input  logic                 clk,
    input  logic                 rstN,
    input  alsPkg::avgSample_t   avg,
    input  logic                 avgValid,
    input  logic                 creditReturn,
    output alsPkg::lightReport_t report,
    output logic                 reportValid
);

    import alsPkg::*;

    localparam int CRED_W = $clog2(`ALS_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              canSend;
    logic              candValid;
    logic              sendNow;
    logic              pendValid;
    lightReport_t      newRep;
    lightReport_t      pendRep;
    lightReport_t      candRep;
    logic [3:0]        dropCnt;
    logic [3:0]        candDropped;

    function automatic lightLevel_t classify(input logic [`ALS_DATA_BITS-1:0] mean);
        if (mean < `ALS_TH_DIM) begin
            return lvDark;
        end else if (mean < `ALS_TH_BRIGHT) begin
            return lvDim;
        end else if (mean < `ALS_TH_SUN) begin
            return lvBright;
        end
        return lvSun;
    endfunction

    always_comb begin
        newRep.level   = classify(avg.mean);
        newRep.mean    = avg.mean;
        newRep.raw     = avg.raw;
        newRep.seq     = avg.seq;
        newRep.dropped = '0;

        // A new report arriving on a full slot replaces it
        if (avgValid && pendValid && dropCnt != 4'hf) begin
            candDropped = dropCnt + 1'b1;
        end else begin
            candDropped = dropCnt;
        end

        candValid       = avgValid || pendValid;
        candRep         = avgValid ? newRep : pendRep;
        candRep.dropped = candDropped;
    end

    // A returning credit can be spent in the same cycle
    assign canSend = (credits != '0) || creditReturn;
    assign sendNow = candValid && canSend;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits     <= CRED_W'(`ALS_CREDITS);
            pendValid   <= 1'b0;
            dropCnt     <= '0;
            reportValid <= 1'b0;
        end else begin
            credits     <= credits + CRED_W'(creditReturn) - CRED_W'(sendNow);
            reportValid <= sendNow;
            if (sendNow) begin
                pendValid <= 1'b0;
                dropCnt   <= '0;
            end else if (avgValid) begin
                pendValid <= 1'b1;
                dropCnt   <= candDropped;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sendNow) begin
            report <= candRep;
        end
        if (avgValid && !sendNow) begin
            pendRep <= newRep;
        end
    end

endmodule

// File: verilog/sampleAverager.sv
// Moving average over the last readings
`include "als_defs.svh"

module sampleAverager (
    input  logic               clk,
    input  logic               rstN,
    input  alsPkg::sample_t    sample,
    input  logic               sampleValid,
    output alsPkg::avgSample_t avg,
    output logic               avgValid
);

    import alsPkg::*;

    localparam int DEPTH = 1 << `ALS_AVG_LOG2;
    localparam int SUM_W = `ALS_DATA_BITS + `ALS_AVG_LOG2;

    logic [`ALS_DATA_BITS-1:0] window [DEPTH];
    logic [SUM_W-1:0]          sum;
    logic [SUM_W-1:0]          sumNext;

    // Oldest entry leaves as the new one enters
    assign sumNext = sum + SUM_W'(sample.value) - SUM_W'(window[DEPTH-1]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                window[i] <= '0;
            end
            sum      <= '0;
            avgValid <= 1'b0;
        end else begin
            avgValid <= sampleValid;
            if (sampleValid) begin
                window[0] <= sample.value;
                for (int i = 1; i < DEPTH; i++) begin
                    window[i] <= window[i-1];
                end
                sum <= sumNext;
            end
        end
    end

    // Truncating divide by the depth
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            avg.raw  <= sample.value;
            avg.mean <= sumNext[SUM_W-1:`ALS_AVG_LOG2];
            avg.seq  <= sample.seq;
        end
    end

endmodule

// File: verilog/alsSpiReader.sv
// SPI frame reader for the light sensor
`include "als_defs.svh"

module alsSpiReader #(
    parameter int QUERY_GAP = `ALS_QUERY_GAP
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            sckRaw,
    input  logic            sckRise,
    input  logic            sdo,
    output logic            cs,
    output logic            sck,
    output alsPkg::sample_t sample,
    output logic            sampleValid
);

    import alsPkg::*;

    localparam int POSTFIX_BITS = `ALS_FRAME_BITS - `ALS_PREFIX_BITS - `ALS_DATA_BITS;
    localparam int CNT_MAX      = (QUERY_GAP > `ALS_FRAME_BITS) ? QUERY_GAP : `ALS_FRAME_BITS;
    localparam int CNT_W        = $clog2(CNT_MAX + 1);

    readerState_t              state;
    logic [CNT_W-1:0]          bitCnt;
    logic [`ALS_DATA_BITS-1:0] shiftBuf;
    logic [7:0]                frameSeq;
    logic                      phaseEnd;
    logic                      gapDone;

    // Last edge of the current frame phase
    always_comb begin
        unique case (state)
            rdPrefix:  phaseEnd = (bitCnt == CNT_W'(`ALS_PREFIX_BITS - 1));
            rdData:    phaseEnd = (bitCnt == CNT_W'(`ALS_DATA_BITS - 1));
            rdPostfix: phaseEnd = (bitCnt == CNT_W'(POSTFIX_BITS - 1));
            default:   phaseEnd = 1'b0;
        endcase
    end

    assign gapDone = (bitCnt == CNT_W'(QUERY_GAP));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= rdIdle;
            bitCnt      <= '0;
            frameSeq    <= '0;
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= 1'b0;
            unique case (state)
                rdIdle: begin
                    // Start only while sck is low so the frame opens cleanly
                    if (gapDone) begin
                        if (!sckRaw) begin
                            state  <= rdPrefix;
                            bitCnt <= '0;
                        end
                    end else if (sckRise) begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                rdPrefix, rdData: begin
                    if (sckRise) begin
                        if (phaseEnd) begin
                            state  <= (state == rdPrefix) ? rdData : rdPostfix;
                            bitCnt <= '0;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
                rdPostfix: begin
                    if (sckRise) begin
                        if (phaseEnd) begin
                            state       <= rdIdle;
                            bitCnt      <= '0;
                            sampleValid <= 1'b1;
                            frameSeq    <= frameSeq + 1'b1;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (sckRise && state == rdData) begin
            shiftBuf <= {shiftBuf[`ALS_DATA_BITS-2:0], sdo};
        end
        if (sckRise && state == rdPostfix && phaseEnd) begin
            sample.value <= shiftBuf;
            sample.seq   <= frameSeq;
        end
    end

    assign cs  = (state == rdIdle);
    assign sck = !cs && sckRaw;

endmodule

// File: verilog/sckDivider.sv
// Serial clock generator
`include "als_defs.svh"

module sckDivider (
    input  logic clk,
    input  logic rstN,
    output logic sckRaw,
    output logic sckRise
);

    localparam int HALF_W = (`ALS_SCK_HALF > 1) ? $clog2(`ALS_SCK_HALF) : 1;

    logic [HALF_W-1:0] halfCnt;
    logic              halfEnd;

    assign halfEnd = (halfCnt == HALF_W'(`ALS_SCK_HALF - 1));

    // Level toggles at the end of each half period
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halfCnt <= '0;
            sckRaw  <= 1'b0;
            sckRise <= 1'b0;
        end else begin
            // Flag lines up with the first high cycle
            sckRise <= halfEnd && !sckRaw;
            if (halfEnd) begin
                halfCnt <= '0;
                sckRaw  <= ~sckRaw;
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/alsPkg.sv
// Light sensor types
`include "als_defs.svh"

package alsPkg;

    typedef enum logic [1:0] {
        rdIdle,
        rdPrefix,
        rdData,
        rdPostfix
    } readerState_t;

    typedef enum logic [1:0] {
        lvDark,
        lvDim,
        lvBright,
        lvSun
    } lightLevel_t;

    typedef struct packed {
        logic [`ALS_DATA_BITS-1:0] value;
        logic [7:0]                seq;
    } sample_t;

    typedef struct packed {
        logic [`ALS_DATA_BITS-1:0] raw;
        logic [`ALS_DATA_BITS-1:0] mean;
        logic [7:0]                seq;
    } avgSample_t;

    // dropped saturates at 15
    typedef struct packed {
        lightLevel_t               level;
        logic [`ALS_DATA_BITS-1:0] mean;
        logic [`ALS_DATA_BITS-1:0] raw;
        logic [7:0]                seq;
        logic [3:0]                dropped;
    } lightReport_t;

endpackage

// File: verilog/als_defs.svh
// Light sensor sizes and timing
`ifndef ALS_DEFS_SVH
`define ALS_DEFS_SVH

// Serial clock half period in clk cycles
`define ALS_SCK_HALF     8

// Frame layout in serial clock edges
`define ALS_PREFIX_BITS  3
`define ALS_DATA_BITS    8
`define ALS_FRAME_BITS   16
`define ALS_QUERY_GAP    4

// Window depth is 1 << ALS_AVG_LOG2
`define ALS_AVG_LOG2     2

`define ALS_TH_DIM       64
`define ALS_TH_BRIGHT    128
`define ALS_TH_SUN       192

`define ALS_CREDITS      4

`endif
